// ==== vlog.f ====
design/cpu_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/idex_reg.sv
design/execute_unit.sv
design/core_datapath.sv
verif/core_assert.sv
verif/core_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build core_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f vlog.f -o core_sim
	./obj_dir/core_sim +verilator+error+limit+100 | tee sim.log
	@if grep -q "SIMULATION PASSED" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verif/core_tb.sv ====
// Testbench for the execute core, runs directed and random instruction streams against an ISA model
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	typedef struct packed {
		int unsigned due;  // Cycle count at which the result is visible
		logic        wv;
		logic [3:0]  wr;
		logic [15:0] wd;
		logic        bt;
		logic [15:0] tg;
		logic [2:0]  fl;
	} exp_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic [15:0] pc;
	logic        wb_valid;
	logic [3:0]  wb_reg;
	logic [15:0] wb_data;
	logic        br_taken;
	logic [15:0] br_target;
	logic [2:0]  flags;

	logic [15:0] m_regs [0:15];  // Architectural registers
	logic [2:0]  m_flags;        // {Z, N, V}
	exp_t        exp_q [$];
	int unsigned cyc;            // Falling edges since the first drive
	int          err_cnt;
	int          to_cnt;
	logic [15:0] next_pc;

	core_datapath UUT (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.br_taken(br_taken), .br_target(br_target), .flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(negedge clk); // Five rising edges in reset
		rst_n = 1'b1;
	end

	task automatic report_mismatch(input string name, input logic [15:0] got, input logic [15:0] want);
		$display("FAILED %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, want, cyc);
		err_cnt++;
	endtask

	// Sequential ISA semantics, one instruction at a time
	task automatic model_issue(input logic v, input logic [15:0] w);
		exp_t        e;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		int          sum;
		logic        wr;
		logic        addsub;
		logic        z;
		logic        n;
		a = m_regs[w[7:4]];
		b = m_regs[w[3:0]];
		res = '0;
		sum = 0;
		wr = v && (w[11:8] != 4'd0); // r0 destination drops everything
		addsub = 1'b0;
		z = m_flags[2];
		n = m_flags[1];
		e = '0;
		e.due = cyc + 2;
		e.wr = w[11:8];
		e.tg = pc + 16'd1 + {{7{w[8]}}, w[8:0]};
		case (w[15:12])
			4'd0: sum = $signed(a) + $signed(b);
			4'd1: sum = $signed(a) - $signed(b);
			4'd2: res = a & b;
			4'd3: res = ~(a | b);
			4'd4: res = a << w[3:0];
			4'd5: res = a >> w[3:0];
			4'd6: res = $signed(a) >>> w[3:0];
			4'd10: res = {w[7:0], m_regs[w[11:8]][7:0]};  // LHB
			4'd11: res = {m_regs[w[11:8]][15:8], w[7:0]}; // LLB
			4'd12: begin
				wr = 1'b0;
				case (w[11:9])
					3'd0: e.bt = !z;
					3'd1: e.bt = z;
					3'd2: e.bt = !z && !n;
					3'd3: e.bt = n;
					3'd4: e.bt = z || !n;
					3'd5: e.bt = z || n;
					3'd6: e.bt = m_flags[0];
					default: e.bt = 1'b1;
				endcase
				e.bt = e.bt && v;
			end
			default: wr = 1'b0; // NOP
		endcase
		if (w[15:12] <= 4'd1) begin
			addsub = 1'b1;
			res = sum[15:0]; // Wraps
		end
		if (wr) begin
			m_regs[w[11:8]] = res;
			if (w[15:12] < 4'd10) begin
				m_flags[2] = (res == 16'd0); // Byte loads leave flags alone
			end
			if (addsub) begin
				m_flags[1] = res[15];
				m_flags[0] = (sum > 32767) || (sum < -32768);
			end
		end
		e.wv = wr;
		e.wd = res;
		e.fl = m_flags;
		exp_q.push_back(e);
	endtask

	task automatic check_due();
		exp_t e;
		while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			e = exp_q.pop_front();
			assert (wb_valid === e.wv) else report_mismatch("wb_valid", wb_valid, e.wv);
			if (e.wv) begin
				assert (wb_reg === e.wr) else report_mismatch("wb_reg", wb_reg, e.wr);
				assert (wb_data === e.wd) else report_mismatch("wb_data", wb_data, e.wd);
			end
			assert (br_taken === e.bt) else report_mismatch("br_taken", br_taken, e.bt);
			if (e.bt) begin
				assert (br_target === e.tg)
					else report_mismatch("br_target", br_target, e.tg);
			end
			assert (flags === e.fl) else report_mismatch("flags", flags, e.fl);
		end
	endtask

	// Check what is due, then drive one cycle on the falling edge
	task automatic step(input logic v, input logic [15:0] w);
		check_due();
		instr_valid = v;
		instr = w;
		pc = next_pc;
		model_issue(v, w);
		if (v) begin
			next_pc = next_pc + 16'd1;
		end
		@(negedge clk);
		cyc++;
	endtask

	// Back to back pair followed by two idle cycles
	task automatic issue_pair(input logic [15:0] w1, input logic [15:0] w2);
		step(1'b1, w1);
		step(1'b1, w2);
		step(1'b0, 16'($urandom)); // Junk word under low valid
		step(1'b0, 16'($urandom));
	endtask

	function automatic logic [15:0] rand_instr();
		logic [3:0] op;
		op = 4'($urandom_range(0, 15));
		if (op > 4'd12) begin
			op = op - 4'd13; // Fold 13..15 onto ADD, SUB, AND
		end
		return {op, 12'($urandom)};
	endfunction

	initial begin
		logic [15:0] w1;
		logic [15:0] w2;
		int          t;
		int          r;
		int          p;
		void'($urandom(99118));
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		next_pc = 16'h0100;
		cyc = 0;
		err_cnt = 0;
		to_cnt = 0;
		m_flags = '0;
		for (r = 0; r < 16; r++) begin
			m_regs[r] = '0;
		end
		t = 0;
		while (rst_n !== 1'b1 && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (rst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			to_cnt++;
		end else begin
			step(1'b0, 16'h0000); // Quiet cycles, flags stay 0
			step(1'b0, 16'h0000);
			issue_pair(16'h0100, 16'h7000); // ADD r1 = r0 + r0, then NOP
			for (r = 1; r < 16; r++) begin
				issue_pair({4'd11, 4'(r), 8'($urandom)}, {4'd10, 4'(r), 8'($urandom)});
			end
			for (r = 0; r < 300; r++) begin
				w1 = rand_instr();
				w2 = rand_instr();
				case ($urandom_range(0, 2))
					0: w2[7:4] = w1[11:8]; // rs forwarded
					1: w2[3:0] = w1[11:8]; // rt forwarded
					default: ;
				endcase
				issue_pair(w1, w2);
			end
			for (r = 0; r < 64; r++) begin
				w1 = {4'($urandom_range(0, 3)), 4'($urandom_range(1, 15)), 8'($urandom)};
				issue_pair(w1, {4'd12, 3'(r % 8), 9'($urandom)}); // All eight conditions
			end
			issue_pair(16'h0012, 16'h7123); // Dropped r0 write, NOP
			issue_pair(16'h1300, 16'h2405); // r0 still reads zero
			t = 0;
			while (exp_q.size() > 0 && t < 8) begin
				check_due();
				@(negedge clk);
				cyc++;
				t++;
			end
			if (exp_q.size() > 0) begin
				$display("Timeout: %0d expected results never came due", exp_q.size());
				to_cnt++;
			end
		end
		p = UUT.u_protocol.fail_cnt;
		$display("Errors: %0d value, %0d timeout, %0d protocol", err_cnt, to_cnt, p);
		if (err_cnt == 0 && to_cnt == 0 && p == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/core_assert.sv ====
// Protocol assertions bound into core_datapath, covering the writeback and branch ports
`timescale 1ns/1ps
`default_nettype none

module core_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       instr_valid,
	input logic       wb_valid,
	input logic [3:0] wb_reg,
	input logic       br_taken,
	input logic [2:0] flags
);

	int   fail_cnt = 0; // Failed assertions so far
	logic issued;       // Any instruction since reset

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issued <= 1'b0;
		end else if (instr_valid) begin
			issued <= 1'b1;
		end
	end

	// Results and branches only two edges after an issue
	result_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_valid || br_taken) |-> $past(instr_valid, 2))
		else begin
			$error("result or branch without an issue two edges earlier");
			fail_cnt++;
		end

	no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> wb_reg != 4'd0)
		else begin
			$error("writeback to register 0");
			fail_cnt++;
		end

	wb_or_branch: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && br_taken))
		else begin
			$error("writeback and taken branch in the same cycle");
			fail_cnt++;
		end

	quiet_until_issue: assert property (@(posedge clk) disable iff (!rst_n)
		!issued |-> (!wb_valid && !br_taken && flags == 3'd0))
		else begin
			$error("outputs active before the first instruction");
			fail_cnt++;
		end

endmodule

bind core_datapath core_assert u_protocol (
	.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid),
	.wb_valid(wb_valid), .wb_reg(wb_reg), .br_taken(br_taken), .flags(flags)
);

`default_nettype wire

// ==== design/core_datapath.sv ====
// Core top level, wires decode, register file, ID/EX register and execute together
`timescale 1ns/1ps
`default_nettype none

module core_datapath (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       instr_valid,
	input  cpu_pkg::instr_t            instr,
	input  logic [cpu_pkg::DATA_W-1:0] pc,
	output logic                       wb_valid,
	output logic [cpu_pkg::REG_W-1:0]  wb_reg,
	output logic [cpu_pkg::DATA_W-1:0] wb_data,
	output logic                       br_taken,
	output logic [cpu_pkg::DATA_W-1:0] br_target,
	output logic [2:0]                 flags
);
	import cpu_pkg::*;

	// Decode side
	logic [REG_W-1:0]  dec_rs_addr;
	logic [REG_W-1:0]  dec_rt_addr;
	logic [REG_W-1:0]  dec_rd_addr;
	alu_op_e           dec_alu_op;
	logic              dec_reg_write;
	logic              dec_is_branch;
	logic              dec_byte_high;
	logic              dec_use_shamt;
	logic [7:0]        dec_imm;
	br_cond_e          dec_br_cond;
	logic [DATA_W-1:0] dec_br_offset;
	logic [DATA_W-1:0] rd_data_1;
	logic [DATA_W-1:0] rd_data_2;

	// Execute side
	logic              ex_valid;
	logic [REG_W-1:0]  ex_rs_addr;
	logic [REG_W-1:0]  ex_rt_addr;
	logic [REG_W-1:0]  ex_rd_addr;
	alu_op_e           ex_alu_op;
	logic              ex_reg_write;
	logic              ex_is_branch;
	logic              ex_byte_high;
	logic              ex_use_shamt;
	logic [7:0]        ex_imm;
	br_cond_e          ex_br_cond;
	logic [DATA_W-1:0] ex_br_offset;
	logic [DATA_W-1:0] ex_rd_data_1;
	logic [DATA_W-1:0] ex_rd_data_2;
	logic [DATA_W-1:0] ex_pc;

	instr_decode u_decode (
		.instr(instr),
		.rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr), .rd_addr(dec_rd_addr),
		.alu_op(dec_alu_op), .reg_write(dec_reg_write), .is_branch(dec_is_branch),
		.byte_high(dec_byte_high), .use_shamt(dec_use_shamt), .imm(dec_imm),
		.br_cond(dec_br_cond), .br_offset(dec_br_offset)
	);

	// Write port is fed straight from the writeback outputs
	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
		.rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
		.wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data)
	);

	idex_reg u_idex (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid),
		.rs_addr_in(dec_rs_addr), .rt_addr_in(dec_rt_addr), .rd_addr_in(dec_rd_addr),
		.alu_op_in(dec_alu_op), .reg_write_in(dec_reg_write), .is_branch_in(dec_is_branch),
		.byte_high_in(dec_byte_high), .use_shamt_in(dec_use_shamt), .imm_in(dec_imm),
		.br_cond_in(dec_br_cond), .br_offset_in(dec_br_offset),
		.rd_data_1_in(rd_data_1), .rd_data_2_in(rd_data_2), .pc_in(pc),
		.ex_valid(ex_valid),
		.rs_addr_out(ex_rs_addr), .rt_addr_out(ex_rt_addr), .rd_addr_out(ex_rd_addr),
		.alu_op_out(ex_alu_op), .reg_write_out(ex_reg_write), .is_branch_out(ex_is_branch),
		.byte_high_out(ex_byte_high), .use_shamt_out(ex_use_shamt), .imm_out(ex_imm),
		.br_cond_out(ex_br_cond), .br_offset_out(ex_br_offset),
		.rd_data_1_out(ex_rd_data_1), .rd_data_2_out(ex_rd_data_2), .pc_out(ex_pc)
	);

	execute_unit u_execute (
		.clk(clk), .rst_n(rst_n), .ex_valid(ex_valid),
		.rs_addr(ex_rs_addr), .rt_addr(ex_rt_addr), .rd_addr(ex_rd_addr),
		.alu_op(ex_alu_op), .reg_write(ex_reg_write), .is_branch(ex_is_branch),
		.byte_high(ex_byte_high), .use_shamt(ex_use_shamt), .imm(ex_imm),
		.br_cond(ex_br_cond), .br_offset(ex_br_offset),
		.rd_data_1(ex_rd_data_1), .rd_data_2(ex_rd_data_2), .pc(ex_pc),
		.wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data),
		.br_taken(br_taken), .br_target(br_target), .flags(flags)
	);

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
// Execute stage with forwarding, ALU, Z/N/V flags, branch decision and registered writeback
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       ex_valid,
	input  logic [cpu_pkg::REG_W-1:0]  rs_addr,
	input  logic [cpu_pkg::REG_W-1:0]  rt_addr,
	input  logic [cpu_pkg::REG_W-1:0]  rd_addr,
	input  cpu_pkg::alu_op_e           alu_op,
	input  logic                       reg_write,
	input  logic                       is_branch,
	input  logic                       byte_high,
	input  logic                       use_shamt,
	input  logic [7:0]                 imm,
	input  cpu_pkg::br_cond_e          br_cond,
	input  logic [cpu_pkg::DATA_W-1:0] br_offset,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_1,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_2,
	input  logic [cpu_pkg::DATA_W-1:0] pc,
	output logic                       wr_en,
	output logic [cpu_pkg::REG_W-1:0]  wr_reg,
	output logic [cpu_pkg::DATA_W-1:0] wr_data,
	output logic                       br_taken,
	output logic [cpu_pkg::DATA_W-1:0] br_target,
	output logic [2:0]                 flags      // {Z, N, V}
);
	import cpu_pkg::*;

	localparam int FLAG_Z = 2;
	localparam int FLAG_N = 1;
	localparam int FLAG_V = 0;

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] src_b;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] result;
	logic              ovf;
	logic              set_nv;
	logic              cond_met;

	// Previous instruction's result is not in the file yet when we read it
	assign op_a  = (wr_en && wr_reg == rs_addr && rs_addr != '0) ? wr_data : rd_data_1;
	assign src_b = (wr_en && wr_reg == rt_addr && rt_addr != '0) ? wr_data : rd_data_2;
	assign op_b  = use_shamt ? {{(DATA_W-REG_W){1'b0}}, rt_addr} : src_b;

	always_comb begin
		result = op_a + op_b;
		ovf    = 1'b0;
		set_nv = 1'b0; // Only ADD/SUB touch N and V
		case (alu_op)
			ALU_ADD: begin
				result = op_a + op_b; // Wraps
				ovf    = (op_a[DATA_W-1] == op_b[DATA_W-1]) &&
				         (result[DATA_W-1] != op_a[DATA_W-1]);
				set_nv = 1'b1;
			end
			ALU_SUB: begin
				result = op_a - op_b;
				ovf    = (op_a[DATA_W-1] != op_b[DATA_W-1]) &&
				         (result[DATA_W-1] != op_a[DATA_W-1]);
				set_nv = 1'b1;
			end
			ALU_AND:  result = op_a & op_b;
			ALU_NOR:  result = ~(op_a | op_b);
			ALU_SLL:  result = op_a << op_b[REG_W-1:0];
			ALU_SRL:  result = op_a >> op_b[REG_W-1:0];
			ALU_SRA:  result = $signed(op_a) >>> op_b[REG_W-1:0];
			ALU_BYTE: result = byte_high ? {imm, op_a[7:0]} : {op_a[DATA_W-1:8], imm};
			default:  result = op_a + op_b;
		endcase
	end

	// Condition against flags left by all earlier instructions
	always_comb begin
		cond_met = 1'b0;
		case (br_cond)
			BR_NE:  cond_met = !flags[FLAG_Z];
			BR_EQ:  cond_met = flags[FLAG_Z];
			BR_GT:  cond_met = !flags[FLAG_Z] && !flags[FLAG_N];
			BR_LT:  cond_met = flags[FLAG_N];
			BR_GE:  cond_met = flags[FLAG_Z] || !flags[FLAG_N];
			BR_LE:  cond_met = flags[FLAG_Z] || flags[FLAG_N];
			BR_OV:  cond_met = flags[FLAG_V];
			BR_UNC: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en    <= 1'b0;
			br_taken <= 1'b0;
			flags    <= '0;
		end else begin
			wr_en    <= ex_valid && reg_write;
			br_taken <= ex_valid && is_branch && cond_met;
			// Flags follow ALU ops that write a register, byte loads leave them
			if (ex_valid && reg_write && alu_op != ALU_BYTE) begin
				flags[FLAG_Z] <= (result == '0);
				if (set_nv) begin
					flags[FLAG_N] <= result[DATA_W-1];
					flags[FLAG_V] <= ovf;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		wr_reg    <= rd_addr;
		wr_data   <= result;
		br_target <= pc + DATA_W'(1) + br_offset; // Relative to next word
	end

endmodule

`default_nettype wire

// ==== design/idex_reg.sv ====
// ID/EX pipeline register, holds one decoded instruction and its operands for execute
`timescale 1ns/1ps
`default_nettype none

module idex_reg (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       instr_valid,
	input  logic [cpu_pkg::REG_W-1:0]  rs_addr_in,
	input  logic [cpu_pkg::REG_W-1:0]  rt_addr_in,
	input  logic [cpu_pkg::REG_W-1:0]  rd_addr_in,
	input  cpu_pkg::alu_op_e           alu_op_in,
	input  logic                       reg_write_in,
	input  logic                       is_branch_in,
	input  logic                       byte_high_in,
	input  logic                       use_shamt_in,
	input  logic [7:0]                 imm_in,
	input  cpu_pkg::br_cond_e          br_cond_in,
	input  logic [cpu_pkg::DATA_W-1:0] br_offset_in,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_1_in,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_2_in,
	input  logic [cpu_pkg::DATA_W-1:0] pc_in,
	output logic                       ex_valid,
	output logic [cpu_pkg::REG_W-1:0]  rs_addr_out,
	output logic [cpu_pkg::REG_W-1:0]  rt_addr_out,
	output logic [cpu_pkg::REG_W-1:0]  rd_addr_out,
	output cpu_pkg::alu_op_e           alu_op_out,
	output logic                       reg_write_out,
	output logic                       is_branch_out,
	output logic                       byte_high_out,
	output logic                       use_shamt_out,
	output logic [7:0]                 imm_out,
	output cpu_pkg::br_cond_e          br_cond_out,
	output logic [cpu_pkg::DATA_W-1:0] br_offset_out,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_1_out,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_2_out,
	output logic [cpu_pkg::DATA_W-1:0] pc_out
);
	import cpu_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid      <= 1'b0;
			reg_write_out <= 1'b0;
			is_branch_out <= 1'b0;
		end else begin
			ex_valid      <= instr_valid;
			reg_write_out <= reg_write_in && instr_valid; // Bubble writes nothing
			is_branch_out <= is_branch_in && instr_valid; // Bubble never branches
		end
	end

	// Operands and fields, only looked at under the qualified controls
	always_ff @(posedge clk) begin
		rs_addr_out   <= rs_addr_in;
		rt_addr_out   <= rt_addr_in;
		rd_addr_out   <= rd_addr_in;
		alu_op_out    <= alu_op_in;
		byte_high_out <= byte_high_in;
		use_shamt_out <= use_shamt_in;
		imm_out       <= imm_in;
		br_cond_out   <= br_cond_in;
		br_offset_out <= br_offset_in;
		rd_data_1_out <= rd_data_1_in;
		rd_data_2_out <= rd_data_2_in;
		pc_out        <= pc_in;
	end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// Sixteen-entry register file, two asynchronous reads and one synchronous write, r0 reads zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::REG_W-1:0]  rs_addr,
	input  logic [cpu_pkg::REG_W-1:0]  rt_addr,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_1,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_2,
	input  logic                       wr_en,
	input  logic [cpu_pkg::REG_W-1:0]  wr_reg,
	input  logic [cpu_pkg::DATA_W-1:0] wr_data
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [0:(1<<REG_W)-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << REG_W); i++) begin
				regs[i] <= '0; // Architectural state starts at zero
			end
		end else if (wr_en && wr_reg != '0) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// No write bypass here, execute forwards the last result itself
	assign rd_data_1 = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rd_data_2 = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
// Instruction decoder, turns one instruction word into register numbers, immediates and control
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  cpu_pkg::instr_t             instr,
	output logic [cpu_pkg::REG_W-1:0]   rs_addr,   // Read port 1
	output logic [cpu_pkg::REG_W-1:0]   rt_addr,   // Read port 2, or shift amount
	output logic [cpu_pkg::REG_W-1:0]   rd_addr,   // Destination
	output cpu_pkg::alu_op_e            alu_op,
	output logic                        reg_write,
	output logic                        is_branch,
	output logic                        byte_high, // LHB rather than LLB
	output logic                        use_shamt, // rt field is an immediate
	output logic [7:0]                  imm,
	output cpu_pkg::br_cond_e           br_cond,
	output logic [cpu_pkg::DATA_W-1:0]  br_offset  // Sign extended
);
	import cpu_pkg::*;

	opcode_e opcode;

	assign opcode  = instr.arith_f.opcode; // Same bits in every view
	assign rd_addr = instr.arith_f.rd;     // imm_f.rd sits on the same bits
	assign imm     = instr.imm_f.imm;
	assign br_cond = instr.branch_f.cond;
	assign br_offset = {{(DATA_W-9){instr.branch_f.offset[8]}}, instr.branch_f.offset};

	always_comb begin
		rs_addr   = instr.arith_f.rs;
		rt_addr   = instr.arith_f.rt;
		alu_op    = ALU_ADD;
		reg_write = 1'b0;
		is_branch = 1'b0;
		byte_high = 1'b0;
		use_shamt = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
				alu_op    = alu_op_e'(opcode[2:0]); // Codes follow opcode order
				reg_write = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				alu_op    = alu_op_e'(opcode[2:0]);
				reg_write = 1'b1;
				use_shamt = 1'b1; // rt not read from file
			end
			OP_LHB, OP_LLB: begin
				rs_addr   = instr.imm_f.rd; // Old rd value for the kept byte
				rt_addr   = '0;
				alu_op    = ALU_BYTE;
				reg_write = 1'b1;
				byte_high = (opcode == OP_LHB);
			end
			OP_B: begin
				rs_addr   = '0;
				rt_addr   = '0;
				is_branch = 1'b1;
			end
			default: begin // NOP
				rs_addr = '0;
				rt_addr = '0;
			end
		endcase
		if (rd_addr == '0) begin
			reg_write = 1'b0; // Writes to r0 are dropped
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
// ISA definitions for the 16-bit execute core, imported by every design file
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 16; // Data and PC width
	localparam int REG_W  = 4;  // Register number width

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_NOR = 4'd3,
		OP_SLL = 4'd4,
		OP_SRL = 4'd5,
		OP_SRA = 4'd6,
		OP_LHB = 4'd10,
		OP_LLB = 4'd11,
		OP_B   = 4'd12  // Anything not listed decodes as NOP
	} opcode_e;

	// ALU codes 0..6 line up with the arithmetic opcodes
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_NOR  = 3'd3,
		ALU_SLL  = 3'd4,
		ALU_SRL  = 3'd5,
		ALU_SRA  = 3'd6,
		ALU_BYTE = 3'd7  // LHB/LLB merge
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NE  = 3'd0,
		BR_EQ  = 3'd1,
		BR_GT  = 3'd2,
		BR_LT  = 3'd3,
		BR_GE  = 3'd4,
		BR_LE  = 3'd5,
		BR_OV  = 3'd6,
		BR_UNC = 3'd7
	} br_cond_e;

	typedef struct packed {
		opcode_e          opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;     // Shift amount for SLL/SRL/SRA
	} arith_t;

	typedef struct packed {
		opcode_e          opcode;
		logic [REG_W-1:0] rd;
		logic [7:0]       imm;    // Byte for LHB/LLB
	} imm_t;

	typedef struct packed {
		opcode_e           opcode;
		br_cond_e          cond;
		logic signed [8:0] offset; // Word offset from pc + 1
	} branch_t;

	// One instruction word, three field layouts
	typedef union packed {
		arith_t  arith_f;
		imm_t    imm_f;
		branch_t branch_f;
	} instr_t;

endpackage

`default_nettype wire
